//--- design/cpu_isa_pkg.sv
/*
 * Instruction set definitions for the 16-bit core: word, register index and
 * flag types, opcode encoding and instruction field positions
 */
`default_nettype none

package cpu_isa_pkg;

	localparam int WORD_W   = 16;
	localparam int NUM_REGS = 8;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [2:0]        reg_idx_t;
	typedef logic [3:0]        flags_t;

	// Bit positions inside flags_t
	localparam int FLAG_C = 0;
	localparam int FLAG_Z = 1;
	localparam int FLAG_N = 2;
	localparam int FLAG_V = 3;

	typedef enum logic [3:0] {
		OP_ADD  = 4'h0,
		OP_SUB  = 4'h1,
		OP_AND  = 4'h2,
		OP_XOR  = 4'h3,
		OP_MOVC = 4'h4,
		OP_LDI  = 4'h5,
		OP_LD   = 4'h6,
		OP_ST   = 4'h7,
		OP_MFS  = 4'h8,
		OP_BZ   = 4'h9,
		OP_HALT = 4'hf
	} opcode_e;

	// Instruction word fields
	localparam int OPC_MSB  = 15;
	localparam int OPC_LSB  = 12;
	localparam int DST_MSB  = 11;
	localparam int DST_LSB  = 9;
	localparam int SRCA_MSB = 8;
	localparam int SRCA_LSB = 6;
	localparam int SRCB_MSB = 5;
	localparam int SRCB_LSB = 3;
	// Immediate and branch offset share the low byte
	localparam int IMM_MSB  = 7;
	localparam int IMM_LSB  = 0;
	localparam int IMM_W    = IMM_MSB - IMM_LSB + 1;

endpackage

`default_nettype wire

//--- design/cpu_ctrl_pkg.sv
/*
 * Control unit definitions: sequencer states and the encodings of the
 * register write-back and ALU B-operand selects
 */
`default_nettype none

package cpu_ctrl_pkg;

	typedef enum logic [2:0] {
		FETCH      = 3'd0,
		WAIT_FETCH = 3'd1,
		DECODE     = 3'd2,
		EXECUTE    = 3'd3,
		MEM        = 3'd4,
		WAIT_MEM   = 3'd5,
		HALTED     = 3'd6
	} ctrl_state_e;

	localparam ctrl_state_e RESET_STATE = FETCH;

	// Source of the value written into the register file
	typedef enum logic [2:0] {
		ALU_WB  = 3'd0,
		IMM_WB  = 3'd1,
		MEM_WB  = 3'd2,
		STAT_WB = 3'd3
	} wb_sel_e;

	// Second ALU operand
	typedef enum logic [1:0] {
		REGB_SEL  = 2'd0,
		CONST_SEL = 2'd1
	} alub_sel_e;

endpackage

`default_nettype wire

//--- design/reg_file.sv
/*
 * Register file with eight general registers, two combinational read ports,
 * one synchronous write port and a separate program counter
 */
`default_nettype none

module reg_file import cpu_isa_pkg::*; (
	input  wire logic     clk_i,
	input  wire logic     rst_n_i,
	input  wire logic     wr_en_i,
	input  wire reg_idx_t wr_addr_i,
	input  wire word_t    wr_data_i,
	input  wire reg_idx_t rd_addr_a_i,
	input  wire reg_idx_t rd_addr_b_i,
	output word_t         rd_data_a_o,
	output word_t         rd_data_b_o,
	input  wire logic     pc_en_i,
	input  wire word_t    pc_i,
	output word_t         pc_o
);

	word_t regs [NUM_REGS];
	word_t pc_q;

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en_i) begin
			regs[wr_addr_i] <= wr_data_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			pc_q <= '0;
		end else if (pc_en_i) begin
			pc_q <= pc_i;
		end
	end

	assign rd_data_a_o = regs[rd_addr_a_i];
	assign rd_data_b_o = regs[rd_addr_b_i];
	assign pc_o        = pc_q;

	// The destination index comes from the instruction register
	a_wr_addr_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		wr_en_i |-> !$isunknown(wr_addr_i));

endmodule

`default_nettype wire

//--- design/alu_unit.sv
/*
 * Combinational ALU: add, subtract, and, xor and pass-B, with carry, zero,
 * negative and overflow flags
 */
`default_nettype none

module alu_unit import cpu_isa_pkg::*; (
	input  wire opcode_e op_i,
	input  wire word_t   a_i,
	input  wire word_t   b_i,
	output word_t        res_o,
	output flags_t       flags_o
);

	logic [WORD_W:0] sum;
	word_t           res;
	logic            carry;
	logic            ovf;

	always_comb begin
		sum   = '0;
		res   = '0;
		carry = 1'b0;
		ovf   = 1'b0;
		case (op_i)
			OP_ADD: begin
				sum   = {1'b0, a_i} + {1'b0, b_i};
				res   = sum[WORD_W-1:0];
				carry = sum[WORD_W];
				ovf   = (a_i[WORD_W-1] == b_i[WORD_W-1]) &&
				        (res[WORD_W-1] != a_i[WORD_W-1]);
			end
			OP_SUB: begin
				// Carry out of a + ~b + 1 is set when there is no borrow
				sum   = {1'b0, a_i} + {1'b0, ~b_i} + 1'b1;
				res   = sum[WORD_W-1:0];
				carry = sum[WORD_W];
				ovf   = (a_i[WORD_W-1] != b_i[WORD_W-1]) &&
				        (res[WORD_W-1] != a_i[WORD_W-1]);
			end
			OP_AND:  res = a_i & b_i;
			OP_XOR:  res = a_i ^ b_i;
			OP_MOVC: res = b_i;
			default: res = '0;
		endcase
	end

	assign res_o           = res;
	assign flags_o[FLAG_C] = carry;
	assign flags_o[FLAG_Z] = (res == '0);
	assign flags_o[FLAG_N] = res[WORD_W-1];
	assign flags_o[FLAG_V] = ovf;

endmodule

`default_nettype wire

//--- design/cpu_datapath.sv
/*
 * Core datapath: register file, ALU and operand selection, constant table,
 * status register, bus address/data registers and branch target adder
 */
`default_nettype none

module cpu_datapath import cpu_isa_pkg::*, cpu_ctrl_pkg::*; (
	input  wire logic      clk_i,
	input  wire logic      rst_n_i,
	input  wire logic      pc_wr_i,
	input  wire logic      reg_wr_i,
	input  wire logic      ir_wr_i,
	input  wire logic      mdr_wr_i,
	input  wire logic      mar_ld_i,
	input  wire logic      flags_wr_i,
	input  wire logic      pc_branch_i,
	input  wire wb_sel_e   wb_sel_i,
	input  wire alub_sel_e alub_sel_i,
	input  wire opcode_e   alu_op_i,
	input  wire word_t     wb_dat_i,
	output word_t          ir_o,
	output logic           zero_flag_o,
	output word_t          wb_adr_o,
	output word_t          wb_dat_o
);

	word_t    reg_a, reg_b, pc, pc_next;
	word_t    alu_b, alu_res, const_val, wb_value;
	word_t    imm_ext, branch_offs, status_word;
	word_t    ir_q, mdr_q, mar_q, odr_q;
	flags_t   alu_flags, flags_q;
	reg_idx_t dst_idx, srca_idx, srcb_idx;

	assign dst_idx  = ir_q[DST_MSB:DST_LSB];
	assign srca_idx = ir_q[SRCA_MSB:SRCA_LSB];
	assign srcb_idx = ir_q[SRCB_MSB:SRCB_LSB];

	assign imm_ext     = {{(WORD_W-IMM_W){1'b0}}, ir_q[IMM_MSB:IMM_LSB]};
	assign branch_offs = {{(WORD_W-IMM_W){ir_q[IMM_MSB]}}, ir_q[IMM_MSB:IMM_LSB]};
	assign status_word = {{(WORD_W-$bits(flags_t)){1'b0}}, flags_q};

	reg_file u_reg_file (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.wr_en_i     (reg_wr_i),
		.wr_addr_i   (dst_idx),
		.wr_data_i   (wb_value),
		.rd_addr_a_i (srca_idx),
		.rd_addr_b_i (srcb_idx),
		.rd_data_a_o (reg_a),
		.rd_data_b_o (reg_b),
		.pc_en_i     (pc_wr_i),
		.pc_i        (pc_next),
		.pc_o        (pc)
	);

	// Constant table indexed by the B field
	always_comb begin
		case (srcb_idx)
			3'd0:    const_val = 16'h0000;
			3'd1:    const_val = 16'h0001;
			3'd2:    const_val = 16'h0002;
			3'd3:    const_val = 16'h0004;
			3'd4:    const_val = 16'h0008;
			3'd5:    const_val = 16'h0010;
			3'd6:    const_val = 16'h0020;
			default: const_val = 16'hffff;
		endcase
	end

	assign alu_b = (alub_sel_i == CONST_SEL) ? const_val : reg_b;

	alu_unit u_alu (
		.op_i    (alu_op_i),
		.a_i     (reg_a),
		.b_i     (alu_b),
		.res_o   (alu_res),
		.flags_o (alu_flags)
	);

	always_comb begin
		case (wb_sel_i)
			IMM_WB:  wb_value = imm_ext;
			MEM_WB:  wb_value = mdr_q;
			STAT_WB: wb_value = status_word;
			default: wb_value = alu_res;
		endcase
	end

	// A taken branch is relative to the already incremented PC
	assign pc_next = pc + (pc_branch_i ? branch_offs : word_t'(1));

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			flags_q <= '0;
		end else if (flags_wr_i) begin
			flags_q <= alu_flags;
		end
	end

	// ir_wr_i marks an instruction fetch for both the address and the read data
	always_ff @(posedge clk_i) begin
		if (mar_ld_i) begin
			mar_q <= ir_wr_i ? pc : reg_a;
			odr_q <= reg_b;
		end
		if (mdr_wr_i) begin
			if (ir_wr_i) begin
				ir_q <= wb_dat_i;
			end else begin
				mdr_q <= wb_dat_i;
			end
		end
	end

	assign ir_o        = ir_q;
	assign zero_flag_o = flags_q[FLAG_Z];
	assign wb_adr_o    = mar_q;
	assign wb_dat_o    = odr_q;

endmodule

`default_nettype wire

//--- design/cpu_control.sv
/*
 * Control unit: instruction sequencing FSM, decode of the instruction
 * register into datapath strobes and the Wishbone master handshake
 */
`default_nettype none

module cpu_control import cpu_isa_pkg::*, cpu_ctrl_pkg::*; (
	input  wire logic  clk_i,
	input  wire logic  rst_n_i,
	input  wire word_t ir_i,
	input  wire logic  zero_flag_i,
	input  wire logic  wb_ack_i,
	output logic       wb_cyc_o,
	output logic       wb_stb_o,
	output logic       wb_we_o,
	output logic       halted_o,
	output logic       pc_wr_o,
	output logic       reg_wr_o,
	output logic       ir_wr_o,
	output logic       mdr_wr_o,
	output logic       mar_ld_o,
	output logic       flags_wr_o,
	output logic       pc_branch_o,
	output wb_sel_e    wb_sel_o,
	output alub_sel_e  alub_sel_o,
	output opcode_e    alu_op_o
);

	ctrl_state_e state, state_next;
	opcode_e     op;
	logic        bus_active;
	logic        ld_pending;

	assign op = opcode_e'(ir_i[OPC_MSB:OPC_LSB]);

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			state      <= RESET_STATE;
			ld_pending <= 1'b0;
		end else begin
			state      <= state_next;
			// LD data sits in the read data register one cycle after its ack
			ld_pending <= (state == WAIT_MEM) && wb_ack_i && (op == OP_LD);
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			FETCH:      state_next = WAIT_FETCH;
			WAIT_FETCH: if (wb_ack_i) state_next = DECODE;
			DECODE:     state_next = (op == OP_HALT) ? HALTED : EXECUTE;
			EXECUTE:    state_next = (op == OP_LD || op == OP_ST) ? MEM : FETCH;
			MEM:        state_next = WAIT_MEM;
			WAIT_MEM:   if (wb_ack_i) state_next = FETCH;
			HALTED:     state_next = HALTED;
			default:    state_next = FETCH;
		endcase
	end

	always_comb begin
		pc_wr_o     = 1'b0;
		reg_wr_o    = 1'b0;
		ir_wr_o     = 1'b0;
		mdr_wr_o    = 1'b0;
		mar_ld_o    = 1'b0;
		flags_wr_o  = 1'b0;
		pc_branch_o = 1'b0;
		wb_sel_o    = ALU_WB;
		alub_sel_o  = REGB_SEL;
		alu_op_o    = op;
		case (state)
			FETCH: begin
				mar_ld_o = 1'b1;
				ir_wr_o  = 1'b1;
				// Retire a pending LD while IR still holds it
				if (ld_pending) begin
					reg_wr_o = 1'b1;
					wb_sel_o = MEM_WB;
				end
			end
			WAIT_FETCH: begin
				ir_wr_o  = 1'b1;
				mdr_wr_o = wb_ack_i;
				pc_wr_o  = wb_ack_i;
			end
			EXECUTE: begin
				case (op)
					OP_ADD, OP_SUB, OP_AND, OP_XOR: begin
						reg_wr_o   = 1'b1;
						flags_wr_o = 1'b1;
					end
					OP_MOVC: begin
						reg_wr_o   = 1'b1;
						flags_wr_o = 1'b1;
						alub_sel_o = CONST_SEL;
					end
					OP_LDI: begin
						reg_wr_o = 1'b1;
						wb_sel_o = IMM_WB;
					end
					OP_MFS: begin
						reg_wr_o = 1'b1;
						wb_sel_o = STAT_WB;
					end
					OP_BZ: begin
						pc_wr_o     = zero_flag_i;
						pc_branch_o = zero_flag_i;
					end
					default: ;
				endcase
			end
			MEM:      mar_ld_o = 1'b1;
			WAIT_MEM: mdr_wr_o = wb_ack_i;
			default: ;
		endcase
	end

	assign bus_active = (state == WAIT_FETCH) || (state == WAIT_MEM);
	assign wb_cyc_o   = bus_active;
	assign wb_stb_o   = bus_active;
	assign wb_we_o    = (state == WAIT_MEM) && (op == OP_ST);
	assign halted_o   = (state == HALTED);

	a_stb_cyc: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		wb_stb_o |-> wb_cyc_o);

	// Address and data registers must not reload while a cycle is open
	a_bus_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(wb_stb_o && !wb_ack_i) |-> !mar_ld_o ##1 (wb_stb_o && $stable(wb_we_o)));

	a_halt_sticky: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		halted_o |=> halted_o);

endmodule

`default_nettype wire

//--- design/cpu_top.sv
/*
 * Processor core top: control unit and datapath behind one Wishbone master
 */
`default_nettype none

module cpu_top import cpu_isa_pkg::*, cpu_ctrl_pkg::*; (
	input  wire logic  clk_i,
	input  wire logic  rst_n_i,
	output logic       wb_cyc_o,
	output logic       wb_stb_o,
	output logic       wb_we_o,
	output word_t      wb_adr_o,
	output word_t      wb_dat_o,
	input  wire word_t wb_dat_i,
	input  wire logic  wb_ack_i,
	output logic       halted_o
);

	logic      pc_wr, reg_wr, ir_wr, mdr_wr, mar_ld, flags_wr, pc_branch;
	logic      zero_flag;
	wb_sel_e   wb_sel;
	alub_sel_e alub_sel;
	opcode_e   alu_op;
	word_t     ir;

	cpu_control u_control (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.ir_i        (ir),
		.zero_flag_i (zero_flag),
		.wb_ack_i    (wb_ack_i),
		.wb_cyc_o    (wb_cyc_o),
		.wb_stb_o    (wb_stb_o),
		.wb_we_o     (wb_we_o),
		.halted_o    (halted_o),
		.pc_wr_o     (pc_wr),
		.reg_wr_o    (reg_wr),
		.ir_wr_o     (ir_wr),
		.mdr_wr_o    (mdr_wr),
		.mar_ld_o    (mar_ld),
		.flags_wr_o  (flags_wr),
		.pc_branch_o (pc_branch),
		.wb_sel_o    (wb_sel),
		.alub_sel_o  (alub_sel),
		.alu_op_o    (alu_op)
	);

	cpu_datapath u_datapath (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.pc_wr_i     (pc_wr),
		.reg_wr_i    (reg_wr),
		.ir_wr_i     (ir_wr),
		.mdr_wr_i    (mdr_wr),
		.mar_ld_i    (mar_ld),
		.flags_wr_i  (flags_wr),
		.pc_branch_i (pc_branch),
		.wb_sel_i    (wb_sel),
		.alub_sel_i  (alub_sel),
		.alu_op_i    (alu_op),
		.wb_dat_i    (wb_dat_i),
		.ir_o        (ir),
		.zero_flag_o (zero_flag),
		.wb_adr_o    (wb_adr_o),
		.wb_dat_o    (wb_dat_o)
	);

endmodule

`default_nettype wire

//--- testbench/tb_memory.sv
/*
 * Wishbone classic slave memory of 256 words with a programmable number of
 * wait states, plus tasks to load and read back words
 */
`default_nettype none

module tb_memory import cpu_isa_pkg::*; (
	input  wire logic       clk_i,
	input  wire logic       rst_n_i,
	input  wire logic [2:0] wait_states_i,
	input  wire logic       cyc_i,
	input  wire logic       stb_i,
	input  wire logic       we_i,
	input  wire word_t      adr_i,
	input  wire word_t      dat_i,
	output word_t           dat_o,
	output logic            ack_o
);

	localparam int DEPTH = 256;

	word_t      mem [DEPTH];
	word_t      dat_q    = '0;
	logic       ack_q    = 1'b0;
	logic [2:0] wait_cnt = '0;

	// Outputs change on the falling edge, away from the core's sampling edge
	always @(negedge clk_i) begin
		if (!rst_n_i) begin
			ack_q    <= 1'b0;
			wait_cnt <= '0;
		end else if (ack_q) begin
			// One ack per cycle, the master drops stb after it
			ack_q    <= 1'b0;
			wait_cnt <= '0;
		end else if (cyc_i && stb_i) begin
			if (wait_cnt == wait_states_i) begin
				ack_q <= 1'b1;
				if (we_i) begin
					mem[adr_i[7:0]] = dat_i;
				end else begin
					dat_q <= mem[adr_i[7:0]];
				end
			end else begin
				wait_cnt <= wait_cnt + 3'd1;
			end
		end
	end

	assign dat_o = dat_q;
	assign ack_o = ack_q;

	task write_word(input logic [7:0] addr, input word_t data);
		mem[addr] = data;
	endtask

	task read_word(input logic [7:0] addr, output word_t data);
		data = mem[addr];
	endtask

endmodule

`default_nettype wire

//--- testbench/tb_cpu.sv
/*
 * Core testbench: test table, program template, LFSR, ALU reference model,
 * bus and halt checks, per-test reporting
 */
`default_nettype none

module tb_cpu import cpu_isa_pkg::*; ();

	localparam int FETCH_TIMEOUT = 20;
	localparam int HALT_TIMEOUT  = 3000;
	localparam int QUIET_CYCLES  = 40;

	typedef struct {
		opcode_e    op;
		word_t      a;
		word_t      b;
		reg_idx_t   cidx;
		logic [2:0] waits;
		word_t      exp_res;
		word_t      exp_stat;
		word_t      exp_mark;
		word_t      exp_imm;
	} test_row_t;

	logic       clk         = 1'b0;
	logic       rst_n       = 1'b0;
	logic [2:0] wait_states = '0;
	logic       cyc, stb, we, ack, halted;
	word_t      adr, dat_to_mem, dat_from_mem;

	test_row_t   rows [$];
	word_t       const_table [8] = '{16'h0000, 16'h0001, 16'h0002, 16'h0004,
	                                 16'h0008, 16'h0010, 16'h0020, 16'hffff};
	logic [31:0] lfsr_state   = 32'h53c1bd8e;
	int          error_count  = 0;
	int          failed_tests = 0;
	int          cur_test     = 0;

	always #5 clk = ~clk;

	cpu_top dut (
		.clk_i    (clk),
		.rst_n_i  (rst_n),
		.wb_cyc_o (cyc),
		.wb_stb_o (stb),
		.wb_we_o  (we),
		.wb_adr_o (adr),
		.wb_dat_o (dat_to_mem),
		.wb_dat_i (dat_from_mem),
		.wb_ack_i (ack),
		.halted_o (halted)
	);

	tb_memory u_mem (
		.clk_i         (clk),
		.rst_n_i       (rst_n),
		.wait_states_i (wait_states),
		.cyc_i         (cyc),
		.stb_i         (stb),
		.we_i          (we),
		.adr_i         (adr),
		.dat_i         (dat_to_mem),
		.dat_o         (dat_from_mem),
		.ack_o         (ack)
	);

	// Port level rule, stb only inside a cycle
	always @(negedge clk) begin
		if (rst_n && stb && !cyc) begin
			$display("CHECK FAILED at %0t: stb high without cyc", $time);
			error_count++;
		end
	end

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw_bits(input int n, output word_t v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[14:0], lfsr_state[0]};
		end
	endtask

	function automatic word_t enc_reg(opcode_e op, reg_idx_t d, reg_idx_t a, reg_idx_t b);
		return {op, d, a, b, 3'b000};
	endfunction

	function automatic word_t enc_imm(opcode_e op, reg_idx_t d, logic [7:0] imm);
		return {op, d, 1'b0, imm};
	endfunction

	// Flag rules worked out with integer arithmetic
	task automatic alu_model(input opcode_e op, input word_t a, input word_t b,
	                         input reg_idx_t cidx, output word_t res, output flags_t fl);
		int   ua;
		int   ub;
		int   sa;
		int   sb;
		int   full;
		int   sfull;
		logic c;
		logic v;
		ua = a;
		ub = b;
		sa = $signed(a);
		sb = $signed(b);
		c  = 1'b0;
		v  = 1'b0;
		case (op)
			OP_ADD: begin
				full  = ua + ub;
				sfull = sa + sb;
				res   = word_t'(full);
				c     = (full > 65535);
				v     = (sfull > 32767) || (sfull < -32768);
			end
			OP_SUB: begin
				full  = ua - ub;
				sfull = sa - sb;
				res   = word_t'(full);
				// Carry means no borrow
				c     = (ua >= ub);
				v     = (sfull > 32767) || (sfull < -32768);
			end
			OP_AND:  res = a & b;
			OP_XOR:  res = a ^ b;
			default: res = const_table[cidx];
		endcase
		fl = {v, res[15], (res == 16'h0000), c};
	endtask

	task automatic add_row(input opcode_e op, input word_t a_in, input word_t b_in,
	                       input reg_idx_t cidx, input logic [2:0] waits_in, input logic rnd);
		test_row_t row;
		word_t     a;
		word_t     b;
		word_t     w;
		word_t     res;
		flags_t    fl;
		a         = a_in;
		b         = b_in;
		row.waits = waits_in;
		if (rnd) begin
			draw_bits(16, a);
			draw_bits(16, b);
			draw_bits(3, w);
			row.waits = 3'(w % 6);
		end
		alu_model(op, a, b, cidx, res, fl);
		row.op       = op;
		row.a        = a;
		row.b        = b;
		row.cidx     = cidx;
		row.exp_res  = res;
		row.exp_stat = {12'h000, fl};
		row.exp_mark = fl[FLAG_Z] ? 16'h00aa : 16'h0055;
		row.exp_imm  = {8'h00, a[7:0]};
		rows.push_back(row);
	endtask

	task automatic load_program(input test_row_t row);
		reg_idx_t op_b;
		op_b = (row.op == OP_MOVC) ? row.cidx : 3'd4;
		// Unused words hold HALT with the address in the low byte
		for (int i = 0; i < 256; i++) begin
			u_mem.write_word(8'(i), {8'hf0, 8'(i)});
		end
		u_mem.write_word(8'h00, enc_imm(OP_LDI, 3'd1, 8'h80));
		u_mem.write_word(8'h01, enc_reg(OP_LD, 3'd2, 3'd1, 3'd0));
		u_mem.write_word(8'h02, enc_imm(OP_LDI, 3'd3, 8'h81));
		u_mem.write_word(8'h03, enc_reg(OP_LD, 3'd4, 3'd3, 3'd0));
		u_mem.write_word(8'h04, enc_reg(row.op, 3'd5, 3'd2, op_b));
		u_mem.write_word(8'h05, enc_reg(OP_MFS, 3'd6, 3'd0, 3'd0));
		u_mem.write_word(8'h06, enc_imm(OP_LDI, 3'd0, 8'haa));
		// Branch over the next LDI when the zero flag is set
		u_mem.write_word(8'h07, enc_imm(OP_BZ, 3'd0, 8'h01));
		u_mem.write_word(8'h08, enc_imm(OP_LDI, 3'd0, 8'h55));
		u_mem.write_word(8'h09, enc_imm(OP_LDI, 3'd7, 8'h90));
		u_mem.write_word(8'h0a, enc_reg(OP_ST, 3'd0, 3'd7, 3'd5));
		u_mem.write_word(8'h0b, enc_imm(OP_LDI, 3'd7, 8'h91));
		u_mem.write_word(8'h0c, enc_reg(OP_ST, 3'd0, 3'd7, 3'd6));
		u_mem.write_word(8'h0d, enc_imm(OP_LDI, 3'd7, 8'h92));
		u_mem.write_word(8'h0e, enc_reg(OP_ST, 3'd0, 3'd7, 3'd0));
		u_mem.write_word(8'h0f, enc_imm(OP_LDI, 3'd2, row.a[7:0]));
		u_mem.write_word(8'h10, enc_imm(OP_LDI, 3'd7, 8'h93));
		u_mem.write_word(8'h11, enc_reg(OP_ST, 3'd0, 3'd7, 3'd2));
		u_mem.write_word(8'h12, 16'hf000);
		u_mem.write_word(8'h80, row.a);
		u_mem.write_word(8'h81, row.b);
	endtask

	task automatic check_word(input string what, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: test %0d %s got %h expected %h",
			         $time, cur_test, what, got, exp);
			error_count++;
		end
	endtask

	task automatic run_test(input int idx);
		test_row_t row;
		word_t     got;
		int        errors_before;
		int        cnt;
		logic      quiet_bad;
		row           = rows[idx];
		cur_test      = idx;
		errors_before = error_count;
		@(negedge clk);
		rst_n       = 1'b0;
		wait_states = row.waits;
		load_program(row);
		repeat (5) @(negedge clk);
		rst_n = 1'b1;
		if (cyc || stb || we || halted) begin
			$display("CHECK FAILED at %0t: test %0d outputs not idle after reset", $time, idx);
			error_count++;
		end
		cnt = 0;
		while (!stb && cnt < FETCH_TIMEOUT) begin
			@(negedge clk);
			cnt++;
		end
		if (!stb) begin
			$display("Test %0d: no bus cycle started after reset", idx);
			error_count++;
		end else begin
			check_word("first fetch address", adr, 16'h0000);
		end
		cnt = 0;
		while (!halted && cnt < HALT_TIMEOUT) begin
			@(negedge clk);
			cnt++;
		end
		if (!halted) begin
			$display("Test %0d: core did not halt within %0d cycles", idx, HALT_TIMEOUT);
			error_count++;
		end else begin
			quiet_bad = 1'b0;
			for (int i = 0; i < QUIET_CYCLES; i++) begin
				@(negedge clk);
				if (cyc || !halted) begin
					quiet_bad = 1'b1;
				end
			end
			if (quiet_bad) begin
				$display("CHECK FAILED at %0t: test %0d bus active or halt dropped after HALT",
				         $time, idx);
				error_count++;
			end
			u_mem.read_word(8'h90, got);
			check_word("result", got, row.exp_res);
			u_mem.read_word(8'h91, got);
			check_word("status word", got, row.exp_stat);
			u_mem.read_word(8'h92, got);
			check_word("branch marker", got, row.exp_mark);
			u_mem.read_word(8'h93, got);
			check_word("immediate", got, row.exp_imm);
		end
		if (error_count == errors_before) begin
			$display("Test %0d %s a=%h b=%h c=%0d waits=%0d: ok",
			         idx, row.op.name(), row.a, row.b, row.cidx, row.waits);
		end else begin
			failed_tests++;
			$display("Test %0d %s a=%h b=%h c=%0d waits=%0d: FAILED",
			         idx, row.op.name(), row.a, row.b, row.cidx, row.waits);
		end
	endtask

	initial begin
		add_row(OP_ADD, 16'h1234, 16'h0101, 3'd0, 3'd0, 1'b0);
		add_row(OP_ADD, 16'hffff, 16'h0001, 3'd0, 3'd0, 1'b0);
		add_row(OP_ADD, 16'h7fff, 16'h0001, 3'd0, 3'd1, 1'b0);
		add_row(OP_ADD, 16'h8000, 16'h8000, 3'd0, 3'd5, 1'b0);
		// Equal operands take the branch
		add_row(OP_SUB, 16'h0005, 16'h0005, 3'd0, 3'd0, 1'b0);
		add_row(OP_SUB, 16'h0003, 16'h0005, 3'd0, 3'd2, 1'b0);
		add_row(OP_SUB, 16'h8000, 16'h0001, 3'd0, 3'd0, 1'b0);
		add_row(OP_AND, 16'hf0f0, 16'h0ff0, 3'd0, 3'd3, 1'b0);
		add_row(OP_XOR, 16'haaaa, 16'haaaa, 3'd0, 3'd0, 1'b0);
		for (int c = 0; c < 8; c++) begin
			add_row(OP_MOVC, 16'h00c0 + 16'(c), 16'h0000, 3'(c), 3'(c % 6), 1'b0);
		end
		add_row(OP_ADD, 16'h0000, 16'h0000, 3'd0, 3'd0, 1'b1);
		add_row(OP_SUB, 16'h0000, 16'h0000, 3'd0, 3'd0, 1'b1);
		add_row(OP_AND, 16'h0000, 16'h0000, 3'd0, 3'd0, 1'b1);
		add_row(OP_XOR, 16'h0000, 16'h0000, 3'd0, 3'd0, 1'b1);
		add_row(OP_ADD, 16'h0000, 16'h0000, 3'd0, 3'd0, 1'b1);
		add_row(OP_SUB, 16'h0000, 16'h0000, 3'd0, 3'd0, 1'b1);
		for (int i = 0; i < rows.size(); i++) begin
			run_test(i);
		end
		$display("%0d tests run, %0d failed, %0d check errors",
		         rows.size(), failed_tests, error_count);
		if (error_count == 0 && failed_tests == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- tb.f
design/cpu_isa_pkg.sv
design/cpu_ctrl_pkg.sv
design/reg_file.sv
design/alu_unit.sv
design/cpu_datapath.sv
design/cpu_control.sv
design/cpu_top.sv
testbench/tb_memory.sv
testbench/tb_cpu.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the core testbench with Verilator, then search the log for the pass message

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_cpu -f tb.f -o sim_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi

if grep -q "All tests passed" "$LOG"; then
	exit 0
fi

echo "Pass message not found in $LOG"
exit 1
